//--- flist.f
rtl/armCtrlPkg.sv
rtl/condCheck.sv
rtl/instrDecoder.sv
rtl/executeStage.sv
rtl/retireStages.sv
rtl/armController.sv
bench/tbArmController.sv

//--- Bender.yml
package:
  name: armController

sources:
  - rtl/armCtrlPkg.sv
  - rtl/condCheck.sv
  - rtl/instrDecoder.sv
  - rtl/executeStage.sv
  - rtl/retireStages.sv
  - rtl/armController.sv
  - target: simulation
    files:
      - bench/tbArmController.sv

//--- bench/tbArmController.sv
`timescale 1ns/1ns

module tbArmController import armCtrlPkg::*; ();

  localparam int ClkPeriod   = 40;
  localparam int Skew        = 5;       // Input delay after the rising edge
  localparam int ResetCycles = 10;
  localparam int NumCycles   = 2000;
  localparam int DrainCycles = 4;
  localparam int TimeoutNs   = (NumCycles + ResetCycles + 20) * ClkPeriod;

  logic      clk = 1'b0;
  logic      rst, instrValid;
  word_t     instrD, aluResultE;
  flags_t    aluFlagsE;
  aluOp_t    aluControlE;
  logic      aluSrcE, branchTakenE, memWriteM;
  byteMask_t byteMaskM;
  logic      regWriteW, memtoRegW, pcSrcW;
  flags_t    flags;

  integer    seed   = 30;
  integer    errors = 0;
  integer    checks = 0;
  word_t     rnd;

  // Reference model state
  logic        eStrobe;               // Strobe seen one cycle ago
  word_t       eInstr;                // Instruction now in E
  decodeCtrl_t expDec;                // Expected decode of the E entry
  logic        expPass;               // Condition result of the E entry
  memCtrl_t    mExp;
  wbCtrl_t     wExp;
  flags_t      modelFlags;            // In-order flags with every older instruction applied
  flags_t      archExp;               // Expected flags output

  always #(ClkPeriod / 2) clk = ~clk;

  armController i_armController (
    .clk          (clk),
    .rst          (rst),
    .instrValid   (instrValid),
    .instrD       (instrD),
    .aluFlagsE    (aluFlagsE),
    .aluResultE   (aluResultE),
    .aluControlE  (aluControlE),
    .aluSrcE      (aluSrcE),
    .branchTakenE (branchTakenE),
    .memWriteM    (memWriteM),
    .byteMaskM    (byteMaskM),
    .regWriteW    (regWriteW),
    .memtoRegW    (memtoRegW),
    .pcSrcW       (pcSrcW),
    .flags        (flags)
  );

  // ========================================
  // Compare tasks
  // ========================================
  task automatic checkBit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic checkAluOp(input string name, input aluOp_t got, input aluOp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic checkMask(input string name, input byteMask_t got, input byteMask_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic checkFlags(input string name, input flags_t got, input flags_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // ========================================
  // Reference model
  // ========================================
  // Even codes test a flag term, odd codes invert it, 1111 never passes
  function automatic logic condHolds(input cond_t cond, input flags_t f);
    logic n, z, c, v, base;
    {n, z, c, v} = f;
    case (cond[3:1])
      3'd0:    base = z;
      3'd1:    base = c;
      3'd2:    base = n;
      3'd3:    base = v;
      3'd4:    base = c && !z;
      3'd5:    base = (n == v);
      3'd6:    base = !z && (n == v);
      default: base = 1'b1;
    endcase
    return (cond == 4'hF) ? 1'b0 : (base ^ cond[0]);
  endfunction

  task automatic predictDecode();
    aluOp_t op;
    op     = eInstr[24:21];
    expDec = '0;
    if (eStrobe && eInstr[27:26] != 2'b11) begin
      expDec.valid = 1'b1;
      case (eInstr[27:26])
        2'b00: begin
          expDec.aluSrc     = eInstr[25];
          expDec.aluControl = op;
          expDec.flagWrite  = eInstr[20];
          expDec.regWrite   = !(op >= 4'd8 && op <= 4'd11);   // TST..CMN only set flags
        end
        2'b01: begin
          expDec.aluSrc     = !eInstr[25];
          expDec.aluControl = eInstr[23] ? ALU_ADD : ALU_SUB;
          expDec.regWrite   = eInstr[20];                     // LDR
          expDec.memtoReg   = eInstr[20];
          expDec.memWrite   = !eInstr[20];                    // STR
          expDec.byteAccess = eInstr[22];
        end
        default: begin                                        // B
          expDec.aluSrc     = 1'b1;
          expDec.aluControl = ALU_ADD;
          expDec.branch     = 1'b1;
        end
      endcase
      expDec.pcWrite = (expDec.regWrite && eInstr[15:12] == 4'd15) || expDec.branch;
    end
    expPass = expDec.valid && condHolds(eInstr[31:28], modelFlags);
  endtask

  // Retire W, shift M to W, E to M, then take the new strobe into E
  task automatic advanceModel();
    memCtrl_t nextM;
    if (wExp.valid && wExp.setFlags) archExp = wExp.flagsNext;
    wExp = {mExp.valid, mExp.regWrite, mExp.memtoReg, mExp.pcSrc, mExp.setFlags, mExp.flagsNext};
    nextM           = '0;
    nextM.valid     = expDec.valid;
    nextM.regWrite  = expDec.regWrite && expPass;
    nextM.memWrite  = expDec.memWrite && expPass;
    nextM.memtoReg  = expDec.memtoReg;                        // Not gated
    nextM.pcSrc     = expDec.pcWrite && expPass;
    nextM.setFlags  = expDec.flagWrite && expPass;
    nextM.flagsNext = aluFlagsE;
    if ((expDec.memWrite || expDec.memtoReg) && expPass) begin
      if (expDec.byteAccess) nextM.byteMask[aluResultE[1:0]] = 1'b1;
      else nextM.byteMask = 4'b1111;
    end
    mExp = nextM;
    if (nextM.setFlags) modelFlags = aluFlagsE;
    eStrobe = instrValid;
    eInstr  = instrD;
  endtask

  task automatic checkOutputs();
    if (expDec.valid) begin
      checkAluOp("aluControlE", aluControlE, expDec.aluControl);
      checkBit("aluSrcE", aluSrcE, expDec.aluSrc);
    end
    checkBit("branchTakenE", branchTakenE, expDec.branch && expPass);
    checkBit("memWriteM", memWriteM, mExp.memWrite);
    checkMask("byteMaskM", byteMaskM, mExp.byteMask);
    checkBit("regWriteW", regWriteW, wExp.regWrite);
    checkBit("memtoRegW", memtoRegW, wExp.memtoReg);
    checkBit("pcSrcW", pcSrcW, wExp.pcSrc);
    checkFlags("flags", flags, archExp);
  endtask

  // ========================================
  // Stimulus
  // ========================================
  task automatic driveRandom();
    word_t instr;
    rnd        = $random(seed);
    instr      = $random(seed);
    instrValid = (rnd[1:0] != 2'b00);                     // About 75 % strobes
    case (rnd[4:2])
      3'd0, 3'd1, 3'd2: instr[27:26] = 2'b00;
      3'd3, 3'd4, 3'd5: instr[27:26] = 2'b01;
      3'd6:             instr[27:26] = 2'b10;
      default:          instr[27:26] = 2'b11;            // Bubble encoding
    endcase
    if (rnd[5]) instr[31:28] = 4'hE;                     // Half AL and the rest any condition
    if (rnd[7:6] == 2'b00) instr[15:12] = 4'd15;        // PC destination
    if (rnd[9:8] == 2'b00 && instr[27:26] == 2'b00) instr[24:23] = 2'b10;  // Compares
    instrD     = instr;
    rnd        = $random(seed);
    aluFlagsE  = rnd[3:0];
    aluResultE = $random(seed);
  endtask

  initial begin
    rst        = 1'b1;
    instrValid = 1'b0;
    instrD     = '0;
    aluFlagsE  = '0;
    aluResultE = '0;
    eStrobe    = 1'b0;
    eInstr     = '0;
    expDec     = '0;
    expPass    = 1'b0;
    mExp       = '0;
    wExp       = '0;
    modelFlags = '0;
    archExp    = '0;
    repeat (ResetCycles) @(posedge clk);
    #Skew;
    rst = 1'b0;
    repeat (NumCycles) begin
      predictDecode();
      checkOutputs();
      driveRandom();
      advanceModel();
      @(posedge clk);
      #Skew;
    end
    repeat (DrainCycles) begin                           // Let the last entries retire
      predictDecode();
      checkOutputs();
      instrValid = 1'b0;
      advanceModel();
      @(posedge clk);
      #Skew;
    end
    $display("Summary: %0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TimeoutNs);
    $display("Timeout: the run did not finish within %0d ns", TimeoutNs);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- rtl/armController.sv
`timescale 1ns/1ns

module armController import armCtrlPkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      instrValid,
  input  word_t     instrD,
  input  flags_t    aluFlagsE,
  input  word_t     aluResultE,
  output aluOp_t    aluControlE,
  output logic      aluSrcE,
  output logic      branchTakenE,
  output logic      memWriteM,
  output byteMask_t byteMaskM,
  output logic      regWriteW,
  output logic      memtoRegW,
  output logic      pcSrcW,
  output flags_t    flags
);

  decodeCtrl_t ctrlD;
  cond_t       condD;
  memCtrl_t    ctrlE, ctrlM;
  wbCtrl_t     ctrlW;

  assign condD = instrD[CondMsb:CondLsb];   // Travels beside the decoded controls

  instrDecoder i_instrDecoder (
    .instrValid (instrValid),
    .instr      (instrD),
    .ctrl       (ctrlD)
  );

  executeStage i_executeStage (
    .clk          (clk),
    .rst          (rst),
    .ctrlD        (ctrlD),
    .condD        (condD),
    .aluFlagsE    (aluFlagsE),
    .aluResultE   (aluResultE),
    .fwdM         (ctrlM),      // Forwarding sources are the stage registers
    .fwdW         (ctrlW),
    .flagsArch    (flags),
    .aluControlE  (aluControlE),
    .aluSrcE      (aluSrcE),
    .branchTakenE (branchTakenE),
    .ctrlE        (ctrlE)
  );

  retireStages i_retireStages (
    .clk   (clk),
    .rst   (rst),
    .ctrlE (ctrlE),
    .ctrlM (ctrlM),
    .ctrlW (ctrlW),
    .flags (flags)
  );

  // Struct fields out to the datapath
  assign memWriteM = ctrlM.memWrite;
  assign byteMaskM = ctrlM.byteMask;
  assign regWriteW = ctrlW.regWrite;
  assign memtoRegW = ctrlW.memtoReg;
  assign pcSrcW    = ctrlW.pcSrc;

endmodule

//--- rtl/retireStages.sv
`timescale 1ns/1ns

module retireStages import armCtrlPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  memCtrl_t ctrlE,
  output memCtrl_t ctrlM,
  output wbCtrl_t  ctrlW,
  output flags_t   flags
);

  wbCtrl_t wbNext;          // M fields that continue to W

  // ========================================
  // Memory stage
  // ========================================
  always_ff @(posedge clk) begin
    if (rst) begin
      ctrlM <= '0;
    end else begin
      ctrlM <= ctrlE;
    end
  end

  // Lane mask and memWrite end here
  always_comb begin
    wbNext.valid     = ctrlM.valid;
    wbNext.regWrite  = ctrlM.regWrite;
    wbNext.memtoReg  = ctrlM.memtoReg;
    wbNext.pcSrc     = ctrlM.pcSrc;
    wbNext.setFlags  = ctrlM.setFlags;
    wbNext.flagsNext = ctrlM.flagsNext;
  end

  // ========================================
  // Writeback stage
  // ========================================
  always_ff @(posedge clk) begin
    if (rst) begin
      ctrlW <= '0;
    end else begin
      ctrlW <= wbNext;
    end
  end

  // Architectural NZCV written as the W entry retires
  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else if (ctrlW.valid && ctrlW.setFlags) begin
      flags <= ctrlW.flagsNext;
    end
  end

endmodule

//--- rtl/executeStage.sv
`timescale 1ns/1ns

module executeStage import armCtrlPkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  decodeCtrl_t ctrlD,
  input  cond_t       condD,
  input  flags_t      aluFlagsE,
  input  word_t       aluResultE,
  input  memCtrl_t    fwdM,
  input  wbCtrl_t     fwdW,
  input  flags_t      flagsArch,
  output aluOp_t      aluControlE,
  output logic        aluSrcE,
  output logic        branchTakenE,
  output memCtrl_t    ctrlE
);

  decodeCtrl_t ctrlReg;     // Decoded controls held in E
  cond_t       condE;
  flags_t      flagsE;      // Flags seen by the condition check
  logic        condPass;
  logic        condExE;
  logic        cmpKill;
  logic        accessE;
  byteMask_t   byteMaskE;

  // ========================================
  // D to E register
  // ========================================
  always_ff @(posedge clk) begin
    if (rst) begin
      ctrlReg <= '0;
    end else begin
      ctrlReg <= ctrlD;
    end
  end

  always_ff @(posedge clk) begin
    condE <= condD;         // Condition field of the E entry
  end

  // Youngest flag writer in flight wins
  always_comb begin
    if (fwdM.setFlags) begin
      flagsE = fwdM.flagsNext;
    end else if (fwdW.setFlags) begin
      flagsE = fwdW.flagsNext;
    end else begin
      flagsE = flagsArch;
    end
  end

  condCheck i_condCheck (
    .cond  (condE),
    .flags (flagsE),
    .pass  (condPass)
  );

  assign condExE = ctrlReg.valid && condPass;
  assign cmpKill = isCompare(ctrlReg.aluControl);   // Compares never write Rd

  // ========================================
  // Byte lanes
  // ========================================
  assign accessE = (ctrlReg.memWrite || ctrlReg.memtoReg) && condExE;

  always_comb begin
    if (!accessE) begin
      byteMaskE = '0;                               // No access or failed condition
    end else if (ctrlReg.byteAccess) begin
      byteMaskE = byteMask_t'(4'b0001 << aluResultE[1:0]);  // Lane from address LSBs
    end else begin
      byteMaskE = '1;                               // Full word
    end
  end

  // E outputs to the datapath
  assign aluControlE  = ctrlReg.aluControl;
  assign aluSrcE      = ctrlReg.aluSrc;
  assign branchTakenE = ctrlReg.branch && condExE;

  // Memory-stage bundle with writes gated by the condition
  always_comb begin
    ctrlE           = '0;
    ctrlE.valid     = ctrlReg.valid;
    ctrlE.regWrite  = ctrlReg.regWrite && condExE && !cmpKill;
    ctrlE.memWrite  = ctrlReg.memWrite && condExE;
    ctrlE.memtoReg  = ctrlReg.memtoReg;
    ctrlE.pcSrc     = ctrlReg.pcWrite && condExE;
    ctrlE.byteMask  = byteMaskE;
    ctrlE.setFlags  = ctrlReg.flagWrite && condExE;
    ctrlE.flagsNext = aluFlagsE;
  end

endmodule

//--- rtl/instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder import armCtrlPkg::*; (
  input  logic        instrValid,
  input  word_t       instr,
  output decodeCtrl_t ctrl
);

  logic [1:0] instrClass;
  aluOp_t     opcode;
  logic       rdIsPc;

  // Main decoder outputs
  logic       validD, aluSrcD, regWriteD, memWriteD;
  logic       memtoRegD, branchD, byteAccessD;

  // ALU decoder outputs
  aluOp_t     aluControlD;
  logic       flagWriteD;

  assign instrClass = instr[ClassMsb:ClassLsb];
  assign opcode     = instr[OpMsb:OpLsb];
  assign rdIsPc     = (instr[RdMsb:RdLsb] == REG_PC);

  // ========================================
  // Main decoder
  // ========================================
  always_comb begin
    validD      = 1'b0;   // Bubble unless a class matches
    aluSrcD     = 1'b0;
    regWriteD   = 1'b0;
    memWriteD   = 1'b0;
    memtoRegD   = 1'b0;
    branchD     = 1'b0;
    byteAccessD = 1'b0;
    if (instrValid) begin
      case (instrClass)
        CLASS_DP: begin
          validD    = 1'b1;
          aluSrcD   = instr[IBit];          // Immediate operand 2
          regWriteD = !isCompare(opcode);   // TST/TEQ/CMP/CMN write flags only
        end
        CLASS_MEM: begin
          validD      = 1'b1;
          aluSrcD     = !instr[IBit];       // I = 0 means 12-bit immediate offset
          regWriteD   = instr[LBit];
          memtoRegD   = instr[LBit];        // LDR
          memWriteD   = !instr[LBit];       // STR
          byteAccessD = instr[BBit];
        end
        CLASS_BR: begin
          validD  = 1'b1;
          aluSrcD = 1'b1;                   // PC plus offset
          branchD = 1'b1;
        end
        default: ;                          // Class 11 decodes as a bubble
      endcase
    end
  end

  // ========================================
  // ALU decoder
  // ========================================
  always_comb begin
    aluControlD = ALU_ADD;                  // Address add for B and bubbles
    flagWriteD  = 1'b0;
    if (instrClass == CLASS_DP) begin
      aluControlD = opcode;
      flagWriteD  = instr[SBit] && instrValid;
    end else if (instrClass == CLASS_MEM) begin
      aluControlD = instr[UBit] ? ALU_ADD : ALU_SUB;  // Up/down offset
    end
  end

  // Pack the Decode-stage bundle
  always_comb begin
    ctrl            = '0;
    ctrl.valid      = validD;
    ctrl.aluSrc     = aluSrcD;
    ctrl.aluControl = aluControlD;
    ctrl.flagWrite  = flagWriteD;
    ctrl.regWrite   = regWriteD;
    ctrl.memWrite   = memWriteD;
    ctrl.memtoReg   = memtoRegD;
    ctrl.branch     = branchD;
    ctrl.pcWrite    = (regWriteD && rdIsPc) || branchD;  // R15 destination or branch
    ctrl.byteAccess = byteAccessD;
  end

endmodule

//--- rtl/condCheck.sv
`timescale 1ns/1ns

module condCheck import armCtrlPkg::*; (
  input  cond_t  cond,
  input  flags_t flags,
  output logic   pass
);

  logic n, z, c, v;

  assign {n, z, c, v} = flags;

  // ========================================
  // Condition table
  // ========================================
  always_comb begin
    case (cond)
      4'b0000: pass = z;                    // EQ
      4'b0001: pass = !z;                   // NE
      4'b0010: pass = c;                    // CS/HS
      4'b0011: pass = !c;                   // CC/LO
      4'b0100: pass = n;                    // MI
      4'b0101: pass = !n;                   // PL
      4'b0110: pass = v;                    // VS
      4'b0111: pass = !v;                   // VC
      4'b1000: pass = c && !z;              // HI
      4'b1001: pass = !c || z;              // LS
      4'b1010: pass = (n == v);             // GE
      4'b1011: pass = (n != v);             // LT
      4'b1100: pass = !z && (n == v);       // GT
      4'b1101: pass = z || (n != v);        // LE
      4'b1110: pass = 1'b1;                 // AL
      default: pass = 1'b0;                 // NV never executes
    endcase
  end

endmodule

//--- rtl/armCtrlPkg.sv
package armCtrlPkg;

  // ========================================
  // Basic types
  // ========================================
  typedef logic [31:0] word_t;      // Data or instruction word
  typedef logic [3:0]  flags_t;     // {N, Z, C, V}
  typedef logic [3:0]  cond_t;      // Condition field in bits 31:28
  typedef logic [3:0]  aluOp_t;     // Same encoding as the DP opcode field
  typedef logic [3:0]  byteMask_t;  // One enable per byte lane

  // Instruction field positions
  localparam int CondMsb  = 31;
  localparam int CondLsb  = 28;
  localparam int ClassMsb = 27;
  localparam int ClassLsb = 26;
  localparam int IBit     = 25;     // Immediate (DP) or register offset (LDR/STR)
  localparam int OpMsb    = 24;
  localparam int OpLsb    = 21;
  localparam int UBit     = 23;     // Offset added when set
  localparam int BBit     = 22;     // Byte transfer
  localparam int SBit     = 20;     // Set flags in DP only
  localparam int LBit     = 20;     // Load in LDR/STR only
  localparam int RdMsb    = 15;
  localparam int RdLsb    = 12;

  localparam logic [3:0] REG_PC = 4'd15;

  // Instruction classes from bits 27:26
  localparam logic [1:0] CLASS_DP  = 2'b00;
  localparam logic [1:0] CLASS_MEM = 2'b01;
  localparam logic [1:0] CLASS_BR  = 2'b10;

  // ========================================
  // ALU opcodes
  // ========================================
  localparam aluOp_t ALU_ADD = 4'b0100;
  localparam aluOp_t ALU_SUB = 4'b0010;
  localparam aluOp_t ALU_TST = 4'b1000;
  localparam aluOp_t ALU_TEQ = 4'b1001;
  localparam aluOp_t ALU_CMP = 4'b1010;
  localparam aluOp_t ALU_CMN = 4'b1011;

  // Compares only touch the flags
  function automatic logic isCompare(aluOp_t op);
    return (op == ALU_TST) || (op == ALU_TEQ) || (op == ALU_CMP) || (op == ALU_CMN);
  endfunction

  // ========================================
  // Stage control bundles
  // ========================================
  typedef struct packed {
    logic   valid;
    logic   aluSrc;       // 1 selects immediate or offset operand
    aluOp_t aluControl;
    logic   flagWrite;
    logic   regWrite;
    logic   memWrite;
    logic   memtoReg;
    logic   branch;
    logic   pcWrite;      // Write to R15 or branch
    logic   byteAccess;
  } decodeCtrl_t;

  typedef struct packed {
    logic      valid;
    logic      regWrite;
    logic      memWrite;
    logic      memtoReg;
    logic      pcSrc;
    byteMask_t byteMask;
    logic      setFlags;
    flags_t    flagsNext;
  } memCtrl_t;

  typedef struct packed {
    logic   valid;
    logic   regWrite;
    logic   memtoReg;
    logic   pcSrc;
    logic   setFlags;
    flags_t flagsNext;
  } wbCtrl_t;

endpackage
